// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = graph_control_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+test
common/graph_pkg.sv
logic/sync_fifo.sv
logic/rr_arbiter.sv
control/job_dispatch.sv
control/vertex_cu.sv
control/cmd_merge.sv
control/graph_control.sv
test/graph_control_tb.sv

// File: common/graph_pkg.sv
package graph_pkg;

	////////////////////////////////////////////////////////////
	// Sizing
	////////////////////////////////////////////////////////////

	// Vertex compute units built into the array
	localparam int NUM_CU  = 4;
	localparam int CU_ID_W = 2;

	localparam int VERTEX_W   = 16;
	localparam int EDGE_W     = 16;
	localparam int EDGE_CNT_W = 8;
	localparam int VDONE_W    = 16;

	// Queue depths
	localparam int JOB_DEPTH   = 8;
	localparam int CMD_DEPTH   = 4;
	localparam int BURST_DEPTH = 8;

	////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////

	// One vertex and the range of its edges in the edge array
	typedef struct packed {
		logic [VERTEX_W-1:0]   vertex_id;
		logic [EDGE_W-1:0]     edge_start;
		logic [EDGE_CNT_W-1:0] edge_count;
	} vertex_job_t;

	// Edge read request, tagged with the unit that issued it
	typedef struct packed {
		logic [CU_ID_W-1:0]  cu_id;
		logic [VERTEX_W-1:0] vertex_id;
		logic [EDGE_W-1:0]   edge_index;
	} read_cmd_t;

endpackage

// File: control/cmd_merge.sv
`timescale 1ns/1ps

module cmd_merge (
	input  logic                                          clock,
	input  logic                                          rstn,
	input  logic [graph_pkg::NUM_CU-1:0]                  cu_cmd_valid,
	output logic [graph_pkg::NUM_CU-1:0]                  cu_cmd_ready,
	input  graph_pkg::read_cmd_t [graph_pkg::NUM_CU-1:0]  cu_cmd,
	output logic                                          cmd_valid,
	input  logic                                          cmd_ready,
	output graph_pkg::read_cmd_t                          cmd
);

	logic [graph_pkg::NUM_CU-1:0]                 q_valid;
	graph_pkg::read_cmd_t [graph_pkg::NUM_CU-1:0] q_data;
	logic [graph_pkg::NUM_CU-1:0]                 q_grant;
	logic [graph_pkg::NUM_CU-1:0]                 q_request;
	logic                                         burst_in_ready;
	logic                                         merge_valid;
	graph_pkg::read_cmd_t                         merge_cmd;

	////////////////////////////////////////////////////////////
	// Per-unit command queues
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_cu_queue
		sync_fifo #(
			.item_t(graph_pkg::read_cmd_t),
			.DEPTH (graph_pkg::CMD_DEPTH)
		) u_cmd_fifo (
			.clock    (clock),
			.rstn     (rstn),
			.in_valid (cu_cmd_valid[i]),
			.in_ready (cu_cmd_ready[i]),
			.in_data  (cu_cmd[i]),
			.out_valid(q_valid[i]),
			.out_ready(q_grant[i]),
			.out_data (q_data[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Round-robin merge
	////////////////////////////////////////////////////////////

	// No requests while the burst buffer is full
	assign q_request = q_valid & {graph_pkg::NUM_CU{burst_in_ready}};

	rr_arbiter u_arbiter (
		.clock  (clock),
		.rstn   (rstn),
		.request(q_request),
		.advance(merge_valid),
		.grant  (q_grant)
	);

	assign merge_valid = |q_grant;

	always_comb begin
		merge_cmd = '0;
		for (int i = 0; i < graph_pkg::NUM_CU; i++) begin
			if (q_grant[i]) begin
				merge_cmd = q_data[i];
			end
		end
	end

	// Burst buffer feeding the command output
	sync_fifo #(
		.item_t(graph_pkg::read_cmd_t),
		.DEPTH (graph_pkg::BURST_DEPTH)
	) u_burst_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (merge_valid),
		.in_ready (burst_in_ready),
		.in_data  (merge_cmd),
		.out_valid(cmd_valid),
		.out_ready(cmd_ready),
		.out_data (cmd)
	);

endmodule

// File: control/graph_control.sv
`timescale 1ns/1ps

module graph_control (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable_in,
	input  logic [31:0]                   cu_config,
	input  logic                          job_valid,
	output logic                          job_ready,
	input  graph_pkg::vertex_job_t        job,
	output logic                          cmd_valid,
	input  logic                          cmd_ready,
	output graph_pkg::read_cmd_t          cmd,
	output logic [graph_pkg::VDONE_W-1:0] vertex_done,
	output logic [graph_pkg::EDGE_W-1:0]  edge_done
);

	logic                                         enabled;
	logic [31:0]                                  active_cu;
	logic [graph_pkg::NUM_CU-1:0]                 cu_enable;
	logic [graph_pkg::NUM_CU-1:0]                 dispatch_valid;
	logic [graph_pkg::NUM_CU-1:0]                 dispatch_ready;
	graph_pkg::vertex_job_t                       dispatch_job;
	logic [graph_pkg::NUM_CU-1:0]                 cu_cmd_valid;
	logic [graph_pkg::NUM_CU-1:0]                 cu_cmd_ready;
	graph_pkg::read_cmd_t [graph_pkg::NUM_CU-1:0] cu_cmd;
	logic [graph_pkg::VDONE_W-1:0]                cu_vcount [graph_pkg::NUM_CU];
	logic [graph_pkg::EDGE_W-1:0]                 cu_ecount [graph_pkg::NUM_CU];
	logic [graph_pkg::VDONE_W-1:0]                vcount_sum;
	logic [graph_pkg::EDGE_W-1:0]                 ecount_sum;

	////////////////////////////////////////////////////////////
	// Enable and configuration
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled   <= 1'b0;
			active_cu <= '0;
		end else begin
			enabled <= enable_in;
			// Zero config keeps the previous unit count
			if (enabled && (|cu_config)) begin
				active_cu <= cu_config;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < graph_pkg::NUM_CU; i++) begin
			cu_enable[i] = (32'(i) < active_cu);
		end
	end

	////////////////////////////////////////////////////////////
	// Dispatch, compute units and merge
	////////////////////////////////////////////////////////////

	job_dispatch u_dispatch (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.job           (job),
		.cu_enable     (cu_enable),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready),
		.dispatch_job  (dispatch_job)
	);

	for (genvar i = 0; i < graph_pkg::NUM_CU; i++) begin : g_cu
		vertex_cu #(
			.CU_ID(i)
		) u_vertex_cu (
			.clock           (clock),
			.rstn            (rstn),
			.enabled         (cu_enable[i]),
			.job_valid       (dispatch_valid[i]),
			.job_ready       (dispatch_ready[i]),
			.job             (dispatch_job),
			.cmd_valid       (cu_cmd_valid[i]),
			.cmd_ready       (cu_cmd_ready[i]),
			.cmd             (cu_cmd[i]),
			.vertex_count    (cu_vcount[i]),
			.edge_count_total(cu_ecount[i])
		);
	end

	cmd_merge u_merge (
		.clock       (clock),
		.rstn        (rstn),
		.cu_cmd_valid(cu_cmd_valid),
		.cu_cmd_ready(cu_cmd_ready),
		.cu_cmd      (cu_cmd),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd)
	);

	////////////////////////////////////////////////////////////
	// Done totals
	////////////////////////////////////////////////////////////

	always_comb begin
		vcount_sum = '0;
		ecount_sum = '0;
		for (int i = 0; i < graph_pkg::NUM_CU; i++) begin
			vcount_sum = vcount_sum + cu_vcount[i];
			ecount_sum = ecount_sum + cu_ecount[i];
		end
	end

	// Totals trail the unit counters by one cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done <= '0;
			edge_done   <= '0;
		end else begin
			vertex_done <= vcount_sum;
			edge_done   <= ecount_sum;
		end
	end

endmodule

// File: control/job_dispatch.sv
`timescale 1ns/1ps

module job_dispatch (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  logic                         job_valid,
	output logic                         job_ready,
	input  graph_pkg::vertex_job_t       job,
	input  logic [graph_pkg::NUM_CU-1:0] cu_enable,
	output logic [graph_pkg::NUM_CU-1:0] dispatch_valid,
	input  logic [graph_pkg::NUM_CU-1:0] dispatch_ready,
	output graph_pkg::vertex_job_t       dispatch_job
);

	logic                         queue_in_ready;
	logic                         head_valid;
	logic                         head_pop;
	logic [graph_pkg::NUM_CU-1:0] cu_request;
	logic [graph_pkg::NUM_CU-1:0] cu_grant;

	////////////////////////////////////////////////////////////
	// Job queue
	////////////////////////////////////////////////////////////

	assign job_ready = enabled && queue_in_ready;

	sync_fifo #(
		.item_t(graph_pkg::vertex_job_t),
		.DEPTH (graph_pkg::JOB_DEPTH)
	) u_job_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (job_valid && enabled),
		.in_ready (queue_in_ready),
		.in_data  (job),
		.out_valid(head_valid),
		.out_ready(head_pop),
		.out_data (dispatch_job)
	);

	////////////////////////////////////////////////////////////
	// Hand-off to idle units
	////////////////////////////////////////////////////////////

	// Only idle, enabled units compete for the head job
	assign cu_request = dispatch_ready & cu_enable & {graph_pkg::NUM_CU{head_valid}};

	rr_arbiter u_arbiter (
		.clock  (clock),
		.rstn   (rstn),
		.request(cu_request),
		.advance(head_pop),
		.grant  (cu_grant)
	);

	// Grant is one-hot, so at most one unit takes a job
	assign dispatch_valid = cu_grant;
	assign head_pop       = |(dispatch_valid & dispatch_ready);

endmodule

// File: control/vertex_cu.sv
`timescale 1ns/1ps

module vertex_cu #(
	parameter int CU_ID = 0
) (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              enabled,
	input  logic                              job_valid,
	output logic                              job_ready,
	input  graph_pkg::vertex_job_t            job,
	output logic                              cmd_valid,
	input  logic                              cmd_ready,
	output graph_pkg::read_cmd_t              cmd,
	output logic [graph_pkg::VDONE_W-1:0]     vertex_count,
	output logic [graph_pkg::EDGE_W-1:0]      edge_count_total
);

	graph_pkg::vertex_job_t              cur_job;
	logic                                busy;
	logic [graph_pkg::EDGE_CNT_W-1:0]    edge_offset;
	logic                                last_done;

	assign job_ready = enabled && !busy;

	// All edges of the job have been issued
	assign last_done = (edge_offset == cur_job.edge_count);

	////////////////////////////////////////////////////////////
	// Command generation
	////////////////////////////////////////////////////////////

	assign cmd_valid      = busy && !last_done;
	assign cmd.cu_id      = graph_pkg::CU_ID_W'(CU_ID);
	assign cmd.vertex_id  = cur_job.vertex_id;
	assign cmd.edge_index = cur_job.edge_start + graph_pkg::EDGE_W'(edge_offset);

	always_ff @(posedge clock) begin
		if (job_valid && job_ready) begin
			cur_job <= job;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy             <= 1'b0;
			edge_offset      <= '0;
			vertex_count     <= '0;
			edge_count_total <= '0;
		end else begin
			if (job_valid && job_ready) begin
				busy        <= 1'b1;
				edge_offset <= '0;
			end else if (busy) begin
				if (last_done) begin
					// Job retires one edge after its final command
					busy             <= 1'b0;
					vertex_count     <= vertex_count + 1'b1;
					edge_count_total <= edge_count_total +
						graph_pkg::EDGE_W'(cur_job.edge_count);
				end else if (cmd_ready) begin
					edge_offset <= edge_offset + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic [graph_pkg::NUM_CU-1:0] request,
	input  logic                        advance,
	output logic [graph_pkg::NUM_CU-1:0] grant
);

	logic [graph_pkg::CU_ID_W-1:0] last_idx;
	logic [graph_pkg::CU_ID_W-1:0] grant_idx;
	logic                          found;

	// Search starts one past the last granted unit
	always_comb begin
		int pos;
		grant     = '0;
		grant_idx = last_idx;
		found     = 1'b0;
		for (int off = 1; off <= graph_pkg::NUM_CU; off++) begin
			pos = (int'(last_idx) + off) % graph_pkg::NUM_CU;
			if (!found && request[pos]) begin
				found         = 1'b1;
				grant[pos]    = 1'b1;
				grant_idx     = pos[graph_pkg::CU_ID_W-1:0];
			end
		end
	end

	// Pointer moves only once the grant is consumed
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// Highest index, so unit 0 wins first
			last_idx <= '1;
		end else if (advance && found) begin
			last_idx <= grant_idx;
		end
	end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic  clock,
	input  logic  rstn,
	input  logic  in_valid,
	output logic  in_ready,
	input  item_t in_data,
	output logic  out_valid,
	input  logic  out_ready,
	output item_t out_data
);

	item_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       push;
	logic                       pop;

	assign in_ready  = (count != DEPTH);
	assign out_valid = (count != 0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_data  = mem[rd_ptr];

	// Storage holds payload only
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves occupancy alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: test/tb_table.svh
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

localparam int NUM_TESTS = 4;
localparam int MAX_JOBS  = 6;

// Columns: active_cu, random cmd_ready (1) or always ready (0), number of jobs
int test_cfg [NUM_TESTS][3] = '{
	'{1, 0, 4},
	'{4, 0, 6},
	'{3, 1, 6},
	'{2, 1, 5}
};

// Columns: vertex_id, edge_start, edge_count
// Rows past the job count of a test are unused
int job_tab [NUM_TESTS][MAX_JOBS][3] = '{
	'{'{'h0010, 0, 3}, '{'h0011, 3, 0}, '{'h0012, 3, 5},
		'{'h0013, 8, 2}, '{0, 0, 0}, '{0, 0, 0}},
	'{'{'h0100, 100, 4}, '{'h0101, 104, 1}, '{'h0102, 105, 7},
		'{'h0103, 112, 3}, '{'h0104, 115, 0}, '{'h0105, 115, 6}},
	'{'{'h0200, 200, 6}, '{'h0201, 206, 2}, '{'h0202, 208, 9},
		'{'h0203, 217, 0}, '{'h0204, 217, 4}, '{'h0205, 221, 5}},
	'{'{'h0300, 300, 8}, '{'h0301, 308, 3}, '{'h0302, 311, 12},
		'{'h0303, 323, 1}, '{'h0304, 324, 7}, '{0, 0, 0}}
};

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

// File: test/graph_control_tb.sv
`timescale 1ns/1ps

module graph_control_tb;

	logic                          clock = 1'b0;
	logic                          rstn;
	logic                          enable_in;
	logic [31:0]                   cu_config;
	logic                          job_valid;
	logic                          job_ready;
	graph_pkg::vertex_job_t        job;
	logic                          cmd_valid;
	logic                          cmd_ready = 1'b0;
	graph_pkg::read_cmd_t          cmd;
	logic [graph_pkg::VDONE_W-1:0] vertex_done;
	logic [graph_pkg::EDGE_W-1:0]  edge_done;

	`include "tb_table.svh"

	int                   exp_vertex [$];
	int                   exp_edge [$];
	int                   exp_job [$];
	int                   last_job [graph_pkg::NUM_CU];
	int                   last_edge [graph_pkg::NUM_CU];
	int                   cur_active = 0;
	int                   random_ready = 0;
	int                   exp_vdone = 0;
	int                   exp_edone = 0;
	int                   errors = 0;
	int                   checks = 0;
	int                   limit = 0;
	logic [31:0]          rnd = 32'd66436;
	logic                 hold = 1'b0;
	graph_pkg::read_cmd_t held_cmd;

	graph_control u_dut (
		.clock      (clock),
		.rstn       (rstn),
		.enable_in  (enable_in),
		.cu_config  (cu_config),
		.job_valid  (job_valid),
		.job_ready  (job_ready),
		.job        (job),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd),
		.vertex_done(vertex_done),
		.edge_done  (edge_done)
	);

	always #20 clock = ~clock;

	// Output back-pressure, about three cycles in four when random
	always @(negedge clock) begin
		if (random_ready != 0) begin
			rnd = xorshift(rnd);
			cmd_ready = |rnd[1:0];
		end else begin
			cmd_ready = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Scoreboard
	////////////////////////////////////////////////////////////

	task automatic check_cmd(input graph_pkg::read_cmd_t c);
		int found;
		int j;
		int u;
		found = -1;
		foreach (exp_vertex[i]) begin
			if (found < 0 && exp_vertex[i] == int'(c.vertex_id) &&
				exp_edge[i] == int'(c.edge_index)) begin
				found = i;
			end
		end
		checks++;
		assert (found >= 0) else begin
			$display("command for vertex %h edge %h at %0t was not expected or came twice",
				c.vertex_id, c.edge_index, $time);
			errors++;
		end
		if (found >= 0) begin
			j = exp_job[found];
			u = int'(c.cu_id);
			exp_vertex.delete(found);
			exp_edge.delete(found);
			exp_job.delete(found);
			checks += 2;
			assert (u < cur_active) else begin
				$display("error at %0t: cmd.cu_id got %0d expected below %0d",
					$time, u, cur_active);
				errors++;
			end
			assert (j > last_job[u] || (j == last_job[u] && int'(c.edge_index) > last_edge[u]))
			else begin
				$display("unit %0d sent edge %h of job %0d out of order at %0t",
					u, c.edge_index, j, $time);
				errors++;
			end
			last_job[u]  = j;
			last_edge[u] = int'(c.edge_index);
		end
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			// Output must hold while stalled
			if (hold) begin
				checks++;
				assert (cmd_valid && cmd == held_cmd) else begin
					$display("error at %0t: cmd got valid %b data %h expected valid 1 data %h",
						$time, cmd_valid, cmd, held_cmd);
					errors++;
				end
			end
			hold     = cmd_valid && !cmd_ready;
			held_cmd = cmd;
			if (cmd_valid && cmd_ready) begin
				check_cmd(cmd);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic send_job(input int t, input int k);
		@(negedge clock);
		job_valid       = 1'b1;
		job.vertex_id  = graph_pkg::VERTEX_W'(job_tab[t][k][0]);
		job.edge_start = graph_pkg::EDGE_W'(job_tab[t][k][1]);
		job.edge_count = graph_pkg::EDGE_CNT_W'(job_tab[t][k][2]);
		@(posedge clock);
		while (!job_ready) begin
			@(posedge clock);
		end
	endtask

	task automatic run_test(input int t);
		int err_before;
		int ncmds;
		err_before = errors;
		ncmds      = 0;
		cur_active = test_cfg[t][0];
		for (int u = 0; u < graph_pkg::NUM_CU; u++) begin
			last_job[u]  = -1;
			last_edge[u] = -1;
		end
		// Each job expands to edge_start .. edge_start + edge_count - 1
		for (int k = 0; k < test_cfg[t][2]; k++) begin
			for (int e = 0; e < job_tab[t][k][2]; e++) begin
				exp_vertex.push_back(job_tab[t][k][0]);
				exp_edge.push_back(job_tab[t][k][1] + e);
				exp_job.push_back(k);
				ncmds++;
			end
			exp_vdone += 1;
			exp_edone += job_tab[t][k][2];
		end
		@(posedge clock);
		random_ready = test_cfg[t][1];
		@(negedge clock);
		cu_config = 32'(cur_active);
		repeat (2) @(negedge clock);
		for (int k = 0; k < test_cfg[t][2]; k++) begin
			send_job(t, k);
		end
		@(negedge clock);
		job_valid = 1'b0;
		while (exp_vertex.size() != 0 || int'(vertex_done) < exp_vdone) begin
			@(posedge clock);
		end
		// Window for stray commands still in the queues
		repeat (graph_pkg::CMD_DEPTH + graph_pkg::BURST_DEPTH) @(posedge clock);
		checks += 2;
		assert (int'(vertex_done) == exp_vdone) else begin
			$display("error at %0t: vertex_done got %0d expected %0d",
				$time, vertex_done, exp_vdone);
			errors++;
		end
		assert (int'(edge_done) == exp_edone) else begin
			$display("error at %0t: edge_done got %0d expected %0d",
				$time, edge_done, exp_edone);
			errors++;
		end
		$display("test %0d: active_cu %0d, %0d jobs, %0d commands, %0d errors",
			t, cur_active, test_cfg[t][2], ncmds, errors - err_before);
	endtask

	initial begin
		int total;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += test_cfg[t][2];
			for (int k = 0; k < test_cfg[t][2]; k++) begin
				total += job_tab[t][k][2];
			end
		end
		limit     = 2 * total + 200;
		rstn      = 1'b0;
		enable_in = 1'b0;
		cu_config = '0;
		job_valid = 1'b0;
		job       = '0;
		repeat (8) @(negedge clock);
		rstn = 1'b1;
		@(posedge clock);
		checks += 4;
		assert (!cmd_valid) else begin
			$display("error at %0t: cmd_valid got %b expected 0", $time, cmd_valid);
			errors++;
		end
		assert (!job_ready) else begin
			$display("error at %0t: job_ready got %b expected 0", $time, job_ready);
			errors++;
		end
		assert (vertex_done == '0) else begin
			$display("error at %0t: vertex_done got %0d expected 0", $time, vertex_done);
			errors++;
		end
		assert (edge_done == '0) else begin
			$display("error at %0t: edge_done got %0d expected 0", $time, edge_done);
			errors++;
		end
		@(negedge clock);
		enable_in = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		int n;
		n = 0;
		@(posedge clock);
		while (n < limit) begin
			@(posedge clock);
			n++;
		end
		$display("timeout after %0d cycles, the tests did not finish", n);
		$display("TEST FAILED");
		$finish;
	end

endmodule
